//--- dual_port_bram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_bram #(
  parameter int ADDR_W = 8,
  parameter int DATA_W = 16
) (
  input  logic              bus_clk,
  input  logic              en_a,
  input  logic              we_a,
  input  logic [ADDR_W-1:0] addr_a,
  input  logic [DATA_W-1:0] din_a,
  output logic [DATA_W-1:0] dout_a,
  input  logic              en_b,
  input  logic              we_b,
  input  logic [ADDR_W-1:0] addr_b,
  input  logic [DATA_W-1:0] din_b,
  output logic [DATA_W-1:0] dout_b
);

  localparam int DEPTH = 2 ** ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];

  // Read registers start at zero so outputs are defined before any read
  logic [DATA_W-1:0] rd_a = '0;
  logic [DATA_W-1:0] rd_b = '0;

  // Both ports in one process
  // Reads return the old word on a write, port B wins a same-address clash
  always_ff @(posedge bus_clk) begin
    if (en_a) begin
      rd_a <= mem[addr_a];
      if (we_a) begin
        mem[addr_a] <= din_a;
      end
    end
    if (en_b) begin
      rd_b <= mem[addr_b];
      if (we_b) begin
        mem[addr_b] <= din_b;
      end
    end
  end

  assign dout_a = rd_a;
  assign dout_b = rd_b;

endmodule

`default_nettype wire

//--- filelist.f
memory_pkg.sv
dual_port_bram.sv
segmented_bram_bank.sv
wr_bank_regs.sv
memory.sv
memory_assertions.sv
memory_tb.sv

//--- memory.sv
`timescale 1ns/1ps
`default_nettype none

module memory #(
  parameter int NUM_SEGMENT = 2,
  parameter int MOD_ADDR_W = 10,
  parameter int STM_ADDR_W = 10,
  parameter int STM_PAGE_W = 2
) (
  input  logic                                  bus_clk,
  input  logic                                  rst,
  // Host bus
  input  memory_pkg::bram_select_t              select,
  input  logic                                  en,
  input  logic                                  we,
  input  logic [memory_pkg::HOST_ADDR_W-1:0]    addr,
  input  logic [memory_pkg::DATA_W-1:0]         data_in,
  output logic [memory_pkg::DATA_W-1:0]         data_out,
  // Controller RAM, core side
  input  logic                                  ctl_we,
  input  logic [7:0]                            ctl_addr,
  input  logic [memory_pkg::DATA_W-1:0]         ctl_din,
  output logic [memory_pkg::DATA_W-1:0]         ctl_dout,
  // Phase correction table
  input  logic [6:0]                            phase_corr_idx,
  output logic [7:0]                            phase_corr_value,
  // PWE table
  input  logic [7:0]                            pwe_idx,
  output logic [8:0]                            pwe_value,
  // Modulation samples
  input  logic [$clog2(NUM_SEGMENT)-1:0]        mod_segment,
  input  logic [MOD_ADDR_W-1:0]                 mod_idx,
  output logic [7:0]                            mod_value,
  // STM samples
  input  logic [$clog2(NUM_SEGMENT)-1:0]        stm_segment,
  input  logic [STM_PAGE_W+STM_ADDR_W-1:0]      stm_idx,
  output logic [memory_pkg::DATA_W-1:0]         stm_value
);

  import memory_pkg::*;

  localparam int SEG_W = $clog2(NUM_SEGMENT);
  localparam int STM_W = STM_PAGE_W + STM_ADDR_W;

  logic [CNT_SEL_W-1:0] cnt_sel;
  logic                 ctl_en;
  logic                 phase_corr_en;
  logic                 pwe_table_en;
  logic                 mod_wr;
  logic                 stm_wr;

  // Bank register outputs
  logic                  mod_wr_segment;
  logic                  stm_wr_segment;
  logic [STM_PAGE_W-1:0] stm_wr_page;
  logic [SEG_W-1:0]      mod_wr_seg;
  logic [SEG_W-1:0]      stm_wr_seg;
  logic [STM_W-1:0]      stm_wr_addr;

  // Full-width read words before trimming
  logic [DATA_W-1:0] phase_corr_dout;
  logic [DATA_W-1:0] pwe_table_dout;
  logic [DATA_W-1:0] mod_dout;

  // Host decode
  assign cnt_sel = addr[HOST_ADDR_W-1:HOST_ADDR_W-CNT_SEL_W];

  assign ctl_en = en & (select == BRAM_SELECT_CONTROLLER)
                  & (cnt_sel == BRAM_CNT_SELECT_MAIN);
  assign phase_corr_en = en & (select == BRAM_SELECT_CONTROLLER)
                         & (cnt_sel == BRAM_CNT_SELECT_PHASE_CORR);
  assign pwe_table_en = en & (select == BRAM_SELECT_PWE_TABLE);

  // Sample memories are write-only from the host
  assign mod_wr = en & we & (select == BRAM_SELECT_MOD);
  assign stm_wr = en & we & (select == BRAM_SELECT_STM);

  dual_port_bram #(
    .ADDR_W(8),
    .DATA_W(DATA_W)
  ) ctl_bram (
    .bus_clk(bus_clk),
    .en_a   (ctl_en),
    .we_a   (we),
    .addr_a (addr[7:0]),
    .din_a  (data_in),
    .dout_a (data_out),
    .en_b   (1'b1),
    .we_b   (ctl_we),
    .addr_b (ctl_addr),
    .din_b  (ctl_din),
    .dout_b (ctl_dout)
  );

  dual_port_bram #(
    .ADDR_W(7),
    .DATA_W(DATA_W)
  ) phase_corr_bram (
    .bus_clk(bus_clk),
    .en_a   (phase_corr_en),
    .we_a   (we),
    .addr_a (addr[6:0]),
    .din_a  (data_in),
    .dout_a (),
    .en_b   (1'b1),
    .we_b   (1'b0),
    .addr_b (phase_corr_idx),
    .din_b  ('0),
    .dout_b (phase_corr_dout)
  );

  dual_port_bram #(
    .ADDR_W(8),
    .DATA_W(DATA_W)
  ) pwe_table_bram (
    .bus_clk(bus_clk),
    .en_a   (pwe_table_en),
    .we_a   (we),
    .addr_a (addr[7:0]),
    .din_a  (data_in),
    .dout_a (),
    .en_b   (1'b1),
    .we_b   (1'b0),
    .addr_b (pwe_idx),
    .din_b  ('0),
    .dout_b (pwe_table_dout)
  );

  assign phase_corr_value = phase_corr_dout[7:0];
  assign pwe_value = pwe_table_dout[8:0];

  // Bank registers watch held writes into the main controller range
  wr_bank_regs #(
    .STM_PAGE_W(STM_PAGE_W)
  ) bank_regs (
    .bus_clk       (bus_clk),
    .rst           (rst),
    .ctl_wr        (we & ctl_en),
    .addr          (addr),
    .data_in       (data_in),
    .mod_wr_segment(mod_wr_segment),
    .stm_wr_segment(stm_wr_segment),
    .stm_wr_page   (stm_wr_page)
  );

  assign mod_wr_seg = SEG_W'(mod_wr_segment);
  assign stm_wr_seg = SEG_W'(stm_wr_segment);

  // Page register on top of the low host address bits
  assign stm_wr_addr = {stm_wr_page, addr[STM_ADDR_W-1:0]};

  segmented_bram_bank #(
    .NUM_SEGMENT(NUM_SEGMENT),
    .ADDR_W     (MOD_ADDR_W)
  ) mod_bank (
    .bus_clk   (bus_clk),
    .wr_en     (mod_wr),
    .wr_segment(mod_wr_seg),
    .wr_addr   (addr[MOD_ADDR_W-1:0]),
    .wr_data   (data_in),
    .rd_segment(mod_segment),
    .rd_addr   (mod_idx),
    .rd_data   (mod_dout)
  );

  assign mod_value = mod_dout[7:0];

  segmented_bram_bank #(
    .NUM_SEGMENT(NUM_SEGMENT),
    .ADDR_W     (STM_W)
  ) stm_bank (
    .bus_clk   (bus_clk),
    .wr_en     (stm_wr),
    .wr_segment(stm_wr_seg),
    .wr_addr   (stm_wr_addr),
    .wr_data   (data_in),
    .rd_segment(stm_segment),
    .rd_addr   (stm_idx),
    .rd_data   (stm_value)
  );

endmodule

`default_nettype wire

//--- memory_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module memory_assertions #(
  parameter int STM_PAGE_W = 2
) (
  input logic                               bus_clk,
  input logic                               rst,
  input logic [2:0]                         wr_hist,
  input logic [memory_pkg::HOST_ADDR_W-1:0] addr,
  input logic                               mod_wr_segment,
  input logic                               stm_wr_segment,
  input logic [STM_PAGE_W-1:0]              stm_wr_page
);

  import memory_pkg::*;

  int failures = 0;

  // Bank registers read zero while reset is held
  property regs_clear_in_reset;
    @(posedge bus_clk) rst |=> (!mod_wr_segment && !stm_wr_segment && stm_wr_page == '0);
  endproperty

  // Any change comes one edge after the history showed off, on, on
  property change_follows_hold;
    @(posedge bus_clk) disable iff (rst)
      (!$past(rst) && !$stable({mod_wr_segment, stm_wr_segment, stm_wr_page}))
      |-> ($past(wr_hist) == 3'b011);
  endproperty

  // Page only moves on a write to its own address
  property page_needs_addr;
    @(posedge bus_clk) disable iff (rst)
      (!$past(rst) && !$stable(stm_wr_page)) |-> ($past(addr) == ADDR_STM_MEM_WR_PAGE);
  endproperty

  a_regs_clear_in_reset: assert property (regs_clear_in_reset) else begin
    failures++;
    $error("bank registers not zero during reset");
  end

  a_change_follows_hold: assert property (change_follows_hold) else begin
    failures++;
    $error("bank register changed without a held write strobe");
  end

  a_page_needs_addr: assert property (page_needs_addr) else begin
    failures++;
    $error("STM write page changed without a write to its address");
  end

endmodule

bind wr_bank_regs memory_assertions #(
  .STM_PAGE_W(STM_PAGE_W)
) bank_regs_checks (
  .bus_clk       (bus_clk),
  .rst           (rst),
  .wr_hist       (wr_hist),
  .addr          (addr),
  .mod_wr_segment(mod_wr_segment),
  .stm_wr_segment(stm_wr_segment),
  .stm_wr_page   (stm_wr_page)
);

`default_nettype wire

//--- memory_pkg.sv
`default_nettype none

package memory_pkg;

  // Host bus word and address widths
  localparam int DATA_W = 16;
  localparam int HOST_ADDR_W = 14;

  // Upper host address bits pick a RAM inside the controller group
  localparam int CNT_SEL_W = 6;

  // RAM group named by the host select lines
  typedef enum logic [1:0] {
    BRAM_SELECT_CONTROLLER = 2'd0,
    BRAM_SELECT_MOD        = 2'd1,
    BRAM_SELECT_PWE_TABLE  = 2'd2,
    BRAM_SELECT_STM        = 2'd3
  } bram_select_t;

  // Sub-ranges of the controller group, compared with addr[13:8]
  localparam logic [CNT_SEL_W-1:0] BRAM_CNT_SELECT_MAIN = 6'd0;
  localparam logic [CNT_SEL_W-1:0] BRAM_CNT_SELECT_PHASE_CORR = 6'd1;

  // Bank register addresses
  // These sit in the main controller range, so the controller RAM
  // keeps a copy of every value written here
  localparam logic [HOST_ADDR_W-1:0] ADDR_MOD_MEM_WR_SEGMENT = 14'h0020;
  localparam logic [HOST_ADDR_W-1:0] ADDR_STM_MEM_WR_SEGMENT = 14'h0021;
  localparam logic [HOST_ADDR_W-1:0] ADDR_STM_MEM_WR_PAGE = 14'h0022;

endpackage

`default_nettype wire

//--- memory_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memory_tb;

  import memory_pkg::*;

  localparam int NUM_SEGMENT = 2;
  localparam int MOD_ADDR_W = 10;
  localparam int STM_ADDR_W = 10;
  localparam int STM_PAGE_W = 2;
  localparam int TIMEOUT_CYCLES = 5000;

  logic                                  bus_clk;
  logic                                  rst;
  bram_select_t                          select;
  logic                                  en;
  logic                                  we;
  logic [HOST_ADDR_W-1:0]                addr;
  logic [DATA_W-1:0]                     data_in;
  logic [DATA_W-1:0]                     data_out;
  logic                                  ctl_we;
  logic [7:0]                            ctl_addr;
  logic [DATA_W-1:0]                     ctl_din;
  logic [DATA_W-1:0]                     ctl_dout;
  logic [6:0]                            phase_corr_idx;
  logic [7:0]                            phase_corr_value;
  logic [7:0]                            pwe_idx;
  logic [8:0]                            pwe_value;
  logic [$clog2(NUM_SEGMENT)-1:0]        mod_segment;
  logic [MOD_ADDR_W-1:0]                 mod_idx;
  logic [7:0]                            mod_value;
  logic [$clog2(NUM_SEGMENT)-1:0]        stm_segment;
  logic [STM_PAGE_W+STM_ADDR_W-1:0]      stm_idx;
  logic [DATA_W-1:0]                     stm_value;

  int     error_count = 0;
  integer seed = 32'h9cf585fb;

  // Reference model of every RAM and bank register
  logic [15:0] ctl_mem [256];
  logic [15:0] phase_mem [128];
  logic [15:0] pwe_mem [256];
  logic [15:0] mod_mem [2][1024];
  logic [15:0] stm_mem [2][4096];
  logic        model_mod_seg;
  logic        model_stm_seg;
  logic [1:0]  model_stm_page;

  memory #(
    .NUM_SEGMENT(NUM_SEGMENT),
    .MOD_ADDR_W (MOD_ADDR_W),
    .STM_ADDR_W (STM_ADDR_W),
    .STM_PAGE_W (STM_PAGE_W)
  ) i_dut (
    .bus_clk(bus_clk), .rst(rst), .select(select), .en(en), .we(we),
    .addr(addr), .data_in(data_in), .data_out(data_out),
    .ctl_we(ctl_we), .ctl_addr(ctl_addr), .ctl_din(ctl_din), .ctl_dout(ctl_dout),
    .phase_corr_idx(phase_corr_idx), .phase_corr_value(phase_corr_value),
    .pwe_idx(pwe_idx), .pwe_value(pwe_value),
    .mod_segment(mod_segment), .mod_idx(mod_idx), .mod_value(mod_value),
    .stm_segment(stm_segment), .stm_idx(stm_idx), .stm_value(stm_value)
  );

  initial begin
    bus_clk = 1'b0;
    forever #50 bus_clk = ~bus_clk;
  end

  // Whole run bounded in clock cycles
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge bus_clk);
    $display("Timeout: test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Something failed");
    $finish;
  end

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge bus_clk);
    end
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    assert (got === exp) else begin
      error_count++;
      $display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  // Decode and bank update rules applied to the model
  task automatic model_write(input bram_select_t sel, input logic [13:0] a,
                             input logic [15:0] d, input bit held);
    case (sel)
      BRAM_SELECT_CONTROLLER: begin
        if (a[13:8] == BRAM_CNT_SELECT_MAIN) begin
          ctl_mem[a[7:0]] = d;
          if (held && a == ADDR_MOD_MEM_WR_SEGMENT) model_mod_seg = d[0];
          if (held && a == ADDR_STM_MEM_WR_SEGMENT) model_stm_seg = d[0];
          if (held && a == ADDR_STM_MEM_WR_PAGE) model_stm_page = d[1:0];
        end else if (a[13:8] == BRAM_CNT_SELECT_PHASE_CORR) begin
          phase_mem[a[6:0]] = d;
        end
      end
      BRAM_SELECT_MOD: mod_mem[model_mod_seg][a[9:0]] = d;
      BRAM_SELECT_PWE_TABLE: pwe_mem[a[7:0]] = d;
      default: stm_mem[model_stm_seg][{model_stm_page, a[9:0]}] = d;
    endcase
  endtask

  // Two-cycle strobe when held and one cycle otherwise, then one idle edge
  task automatic host_write(input bram_select_t sel, input logic [13:0] a,
                            input logic [15:0] d, input bit held);
    @(posedge bus_clk);
    select <= sel;
    en <= 1'b1;
    we <= 1'b1;
    addr <= a;
    data_in <= d;
    @(posedge bus_clk);
    if (held) @(posedge bus_clk);
    en <= 1'b0;
    we <= 1'b0;
    @(posedge bus_clk);
    model_write(sel, a, d, held);
  endtask

  task automatic host_read_check(input logic [13:0] a);
    @(posedge bus_clk);
    select <= BRAM_SELECT_CONTROLLER;
    en <= 1'b1;
    we <= 1'b0;
    addr <= a;
    @(posedge bus_clk);
    en <= 1'b0;
    @(negedge bus_clk);
    check_value("data_out", data_out, ctl_mem[a[7:0]]);
  endtask

  task automatic core_write(input logic [7:0] a, input logic [15:0] d);
    @(posedge bus_clk);
    ctl_we <= 1'b1;
    ctl_addr <= a;
    ctl_din <= d;
    @(posedge bus_clk);
    ctl_we <= 1'b0;
    ctl_mem[a] = d;
  endtask

  // All core read ports checked one cycle after the index
  task automatic read_core(input logic [7:0] c_addr, input logic [6:0] p_idx,
                           input logic [7:0] w_idx, input logic m_seg,
                           input logic [9:0] m_idx, input logic s_seg,
                           input logic [11:0] s_idx);
    @(posedge bus_clk);
    ctl_addr <= c_addr;
    phase_corr_idx <= p_idx;
    pwe_idx <= w_idx;
    mod_segment <= m_seg;
    mod_idx <= m_idx;
    stm_segment <= s_seg;
    stm_idx <= s_idx;
    @(posedge bus_clk);
    @(negedge bus_clk);
    check_value("ctl_dout", ctl_dout, ctl_mem[c_addr]);
    check_value("phase_corr_value", phase_corr_value, phase_mem[p_idx][7:0]);
    check_value("pwe_value", pwe_value, pwe_mem[w_idx][8:0]);
    check_value("mod_value", mod_value, mod_mem[m_seg][m_idx][7:0]);
    check_value("stm_value", stm_value, stm_mem[s_seg][s_idx]);
  endtask

  task automatic apply_reset();
    @(posedge bus_clk);
    rst <= 1'b1;
    en <= 1'b0;
    we <= 1'b0;
    ctl_we <= 1'b0;
    wait_cycles(2);
    rst <= 1'b0;
    model_mod_seg = 1'b0;
    model_stm_seg = 1'b0;
    model_stm_page = 2'd0;
  endtask

  // Known words at index 0 of every RAM, the idle index of the core ports
  task automatic preload_idle_words();
    host_write(BRAM_SELECT_CONTROLLER, 14'h0000, 16'($random(seed)), 1'b1);
    host_write(BRAM_SELECT_CONTROLLER, {BRAM_CNT_SELECT_PHASE_CORR, 8'h00},
               16'($random(seed)), 1'b1);
    host_write(BRAM_SELECT_PWE_TABLE, 14'h0000, 16'($random(seed)), 1'b1);
    host_write(BRAM_SELECT_MOD, 14'h0000, 16'($random(seed)), 1'b1);
    host_write(BRAM_SELECT_STM, 14'h0000, 16'($random(seed)), 1'b1);
  endtask

  task automatic test_controller_ram();
    logic [7:0] a;
    for (int i = 0; i < 8; i++) begin
      a = 8'h40 + 8'(i * 5);
      host_write(BRAM_SELECT_CONTROLLER, {6'd0, a}, 16'($random(seed)), 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      a = 8'h40 + 8'(i * 5);
      host_read_check({6'd0, a});
      read_core(a, 7'd0, 8'd0, 1'b0, 10'd0, 1'b0, 12'd0);
    end
    // Core side write seen by the host
    core_write(8'h90, 16'($random(seed)));
    host_read_check(14'h0090);
  endtask

  task automatic test_tables();
    logic [7:0] idx;
    for (int i = 0; i < 6; i++) begin
      idx = 8'h10 + 8'(i * 3);
      host_write(BRAM_SELECT_CONTROLLER, {6'd0, idx}, 16'($random(seed)), 1'b1);
      host_write(BRAM_SELECT_CONTROLLER, {BRAM_CNT_SELECT_PHASE_CORR, idx},
                 16'($random(seed)), 1'b1);
      host_write(BRAM_SELECT_PWE_TABLE, {6'd0, idx}, 16'($random(seed)), 1'b1);
    end
    for (int i = 0; i < 6; i++) begin
      idx = 8'h10 + 8'(i * 3);
      read_core(idx, idx[6:0], idx, 1'b0, 10'd0, 1'b0, 12'd0);
      host_read_check({6'd0, idx});
    end
  endtask

  task automatic test_mod_segments();
    host_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0000, 1'b1);
    for (int i = 0; i < 8; i++) begin
      host_write(BRAM_SELECT_MOD, 14'(i * 37), 16'($random(seed)), 1'b1);
    end
    host_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0001, 1'b1);
    for (int i = 0; i < 8; i++) begin
      host_write(BRAM_SELECT_MOD, 14'(i * 37), 16'($random(seed)), 1'b1);
    end
    for (int i = 0; i < 8; i++) begin
      read_core(8'd0, 7'd0, 8'd0, 1'b0, 10'(i * 37), 1'b0, 12'd0);
      read_core(8'd0, 7'd0, 8'd0, 1'b1, 10'(i * 37), 1'b0, 12'd0);
    end
  endtask

  task automatic test_stm_pages();
    for (int s = 0; s < 2; s++) begin
      for (int p = 0; p < 4; p++) begin
        host_write(BRAM_SELECT_CONTROLLER, ADDR_STM_MEM_WR_SEGMENT, 16'(s), 1'b1);
        host_write(BRAM_SELECT_CONTROLLER, ADDR_STM_MEM_WR_PAGE, 16'(p), 1'b1);
        for (int j = 0; j < 3; j++) begin
          host_write(BRAM_SELECT_STM, 14'(j * 101 + 7), 16'($random(seed)), 1'b1);
        end
      end
    end
    for (int s = 0; s < 2; s++) begin
      for (int p = 0; p < 4; p++) begin
        for (int j = 0; j < 3; j++) begin
          read_core(8'd0, 7'd0, 8'd0, 1'b0, 10'd0, 1'(s), {2'(p), 10'(j * 101 + 7)});
        end
      end
    end
  endtask

  task automatic test_bank_update();
    host_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0000, 1'b1);
    host_write(BRAM_SELECT_MOD, 14'h0155, 16'($random(seed)), 1'b1);
    host_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0001, 1'b1);
    // Short strobe leaves the segment at 1 but still stores the word
    host_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0010, 1'b0);
    host_read_check(ADDR_MOD_MEM_WR_SEGMENT);
    host_write(BRAM_SELECT_MOD, 14'h0155, 16'($random(seed)), 1'b1);
    read_core(8'd0, 7'd0, 8'd0, 1'b0, 10'h155, 1'b0, 12'd0);
    read_core(8'd0, 7'd0, 8'd0, 1'b1, 10'h155, 1'b0, 12'd0);
    // Held strobe moves writes back to segment 0
    host_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0100, 1'b1);
    host_read_check(ADDR_MOD_MEM_WR_SEGMENT);
    host_write(BRAM_SELECT_MOD, 14'h0155, 16'($random(seed)), 1'b1);
    read_core(8'd0, 7'd0, 8'd0, 1'b0, 10'h155, 1'b0, 12'd0);
    read_core(8'd0, 7'd0, 8'd0, 1'b1, 10'h155, 1'b0, 12'd0);
  endtask

  task automatic test_reset_state();
    host_write(BRAM_SELECT_CONTROLLER, ADDR_MOD_MEM_WR_SEGMENT, 16'h0001, 1'b1);
    host_write(BRAM_SELECT_CONTROLLER, ADDR_STM_MEM_WR_SEGMENT, 16'h0001, 1'b1);
    host_write(BRAM_SELECT_CONTROLLER, ADDR_STM_MEM_WR_PAGE, 16'h0003, 1'b1);
    apply_reset();
    host_write(BRAM_SELECT_MOD, 14'h02aa, 16'($random(seed)), 1'b1);
    host_write(BRAM_SELECT_STM, 14'h00ab, 16'($random(seed)), 1'b1);
    read_core(8'd0, 7'd0, 8'd0, 1'b0, 10'h2aa, 1'b0, {2'b00, 10'h0ab});
  endtask

  initial begin
    int assert_fails;
    rst = 1'b1;
    select = BRAM_SELECT_CONTROLLER;
    en = 1'b0;
    we = 1'b0;
    addr = '0;
    data_in = '0;
    ctl_we = 1'b0;
    ctl_addr = '0;
    ctl_din = '0;
    phase_corr_idx = '0;
    pwe_idx = '0;
    mod_segment = '0;
    mod_idx = '0;
    stm_segment = '0;
    stm_idx = '0;
    apply_reset();
    @(negedge bus_clk);
    check_value("data_out", data_out, 16'h0000);
    preload_idle_words();
    test_controller_ram();
    test_tables();
    test_mod_segments();
    test_stm_pages();
    test_bank_update();
    test_reset_state();
    wait_cycles(2);
    assert_fails = i_dut.bank_regs.bank_regs_checks.failures;
    $display("Errors: %0d mismatches, %0d assertion failures", error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- segmented_bram_bank.sv
`timescale 1ns/1ps
`default_nettype none

module segmented_bram_bank #(
  parameter int NUM_SEGMENT = 2,
  parameter int ADDR_W = 10
) (
  input  logic                           bus_clk,
  // Host write side
  input  logic                           wr_en,
  input  logic [$clog2(NUM_SEGMENT)-1:0] wr_segment,
  input  logic [ADDR_W-1:0]              wr_addr,
  input  logic [memory_pkg::DATA_W-1:0]  wr_data,
  // Core read side
  input  logic [$clog2(NUM_SEGMENT)-1:0] rd_segment,
  input  logic [ADDR_W-1:0]              rd_addr,
  output logic [memory_pkg::DATA_W-1:0]  rd_data
);

  import memory_pkg::*;

  logic              seg_wr  [NUM_SEGMENT];
  logic [DATA_W-1:0] seg_dout [NUM_SEGMENT];

  for (genvar i = 0; i < NUM_SEGMENT; i++) begin : gen_segment
    // Only the segment named by the bank register sees the host write
    assign seg_wr[i] = wr_en & (wr_segment == i);

    dual_port_bram #(
      .ADDR_W(ADDR_W),
      .DATA_W(DATA_W)
    ) seg_bram (
      .bus_clk(bus_clk),
      .en_a   (seg_wr[i]),
      .we_a   (1'b1),
      .addr_a (wr_addr),
      .din_a  (wr_data),
      .dout_a (),
      .en_b   (1'b1),
      .we_b   (1'b0),
      .addr_b (rd_addr),
      .din_b  ('0),
      .dout_b (seg_dout[i])
    );
  end

  // All segments read every cycle
  // so switching rd_segment picks an already registered word
  assign rd_data = seg_dout[rd_segment];

endmodule

`default_nettype wire

//--- wr_bank_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wr_bank_regs #(
  parameter int STM_PAGE_W = 2
) (
  input  logic                               bus_clk,
  input  logic                               rst,
  // Write strobe into the main controller range
  input  logic                               ctl_wr,
  input  logic [memory_pkg::HOST_ADDR_W-1:0] addr,
  input  logic [memory_pkg::DATA_W-1:0]      data_in,
  output logic                               mod_wr_segment,
  output logic                               stm_wr_segment,
  output logic [STM_PAGE_W-1:0]              stm_wr_page
);

  import memory_pkg::*;

  // Oldest sample in bit 2
  logic [2:0] wr_hist;
  logic       wr_held;

  // Strobe was low, then high for two edges in a row
  assign wr_held = (wr_hist == 3'b011);

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      wr_hist <= '0;
    end else begin
      wr_hist <= {wr_hist[1:0], ctl_wr};
    end
  end

  always_ff @(posedge bus_clk) begin
    if (rst) begin
      mod_wr_segment <= 1'b0;
      stm_wr_segment <= 1'b0;
      stm_wr_page    <= '0;
    end else if (wr_held) begin
      case (addr)
        ADDR_MOD_MEM_WR_SEGMENT: begin
          mod_wr_segment <= data_in[0];
        end
        ADDR_STM_MEM_WR_SEGMENT: begin
          stm_wr_segment <= data_in[0];
        end
        ADDR_STM_MEM_WR_PAGE: begin
          stm_wr_page <= data_in[STM_PAGE_W-1:0];
        end
        default: begin
          // Ordinary controller word, no bank change
        end
      endcase
    end
  end

endmodule

`default_nettype wire
